// File: spr_defines.svh
// SPR access unit defines: widths, opcodes, group and register numbers, SR layout
`ifndef SPR_DEFINES_SVH
`define SPR_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////
`define SPR_WIDTH           32      // Data and address width
`define SPR_OFS_WIDTH       16      // Offset from the instruction immediate
`define SPR_SR_WIDTH        16
`define SPR_ALUOP_WIDTH     4
`define SPR_BRANCHOP_WIDTH  3

// Operation codes
`define SPR_ALUOP_MTSR      4'd14   // l.mtspr
`define SPR_ALUOP_MFSR      4'd15   // l.mfspr
`define SPR_BRANCHOP_RFE    3'd6    // Return from exception

////////////////////////////////////////////////////////////////////////////
// Group field and group numbers
////////////////////////////////////////////////////////////////////////////
`define SPR_GROUP_MSB       15
`define SPR_GROUP_LSB       11
`define SPR_NUM_GROUPS      32
`define SPR_GROUP_SYS       5'd0
`define SPR_GROUP_DMMU      5'd1
`define SPR_GROUP_IMMU      5'd2
`define SPR_GROUP_MAC       5'd5
`define SPR_GROUP_DU        5'd6
`define SPR_GROUP_PM        5'd8
`define SPR_GROUP_PIC       5'd9
`define SPR_GROUP_TT        5'd10

// System group register numbers, top of the index is bit 10
`define SPR_SYS_MSB         10
`define SPR_CFGR            7'd0    // Compared on bits 10:4
`define SPR_RF              6'd32   // Compared on bits 10:5
`define SPR_NPC             11'd16
`define SPR_SR              11'd17
`define SPR_PPC             11'd18
`define SPR_EPCR            11'd32
`define SPR_EEAR            11'd48
`define SPR_ESR             11'd64

////////////////////////////////////////////////////////////////////////////
// SR bit positions and reset value
////////////////////////////////////////////////////////////////////////////
`define SPR_SR_SM           0       // Supervisor mode
`define SPR_SR_TEE          1       // Tick timer exception enable
`define SPR_SR_IEE          2       // Interrupt exception enable
`define SPR_SR_DME          5       // Data MMU enable
`define SPR_SR_IME          6       // Insn MMU enable
`define SPR_SR_CE           8       // Top of the low control field
`define SPR_SR_F            9       // Flag
`define SPR_SR_CY           10      // Carry
`define SPR_SR_OV           11      // Bottom of the high field
`define SPR_SR_FO           15      // Fixed one
`define SPR_SR_EPH_DEF      1'b0    // Exception prefix after reset
`define SPR_SR_RESET        {1'b1, `SPR_SR_EPH_DEF, 13'h0000, 1'b1}

`endif

// File: spr_pkg.sv
// SPR access unit package with vector typedefs and request and read-data structs
`default_nettype none

`include "spr_defines.svh"

package spr_pkg;

   // Vectors with an architectural meaning
   typedef logic [`SPR_WIDTH-1:0]          spr_data_t;
   typedef logic [`SPR_WIDTH-1:0]          spr_addr_t;
   typedef logic [`SPR_OFS_WIDTH-1:0]      spr_ofs_t;
   typedef logic [`SPR_SR_WIDTH-1:0]       sr_t;
   typedef logic [`SPR_ALUOP_WIDTH-1:0]    alu_op_t;
   typedef logic [`SPR_BRANCHOP_WIDTH-1:0] branch_op_t;
   typedef logic [`SPR_NUM_GROUPS-1:0]     group_cs_t;    // One bit per group

   ////////////////////////////////////////////////////////////////////////////
   // Requests
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      alu_op_t    alu_op;      // MTSR / MFSR or anything else
      branch_op_t branch_op;   // RFE matters here
      spr_addr_t  addrbase;    // Register operand
      spr_ofs_t   addrofs;     // Immediate
      spr_data_t  wdata;       // l.mtspr source
   } cpu_req_t;

   typedef struct packed {
      spr_addr_t addr;
      spr_data_t wdata;
      logic      read;
      logic      write;        // Wins over read
   } du_req_t;

   typedef struct packed {
      logic flagforw;
      logic flag_we;
      logic cyforw;
      logic cy_we;
   } alu_flags_t;

   ////////////////////////////////////////////////////////////////////////////
   // Read data and enables
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      spr_data_t cfgr;
      spr_data_t rf;
      spr_data_t npc;
      spr_data_t ppc;
      spr_data_t epcr;
      spr_data_t eear;
      sr_t       esr;          // Exception copy of SR
   } sys_rdata_t;

   typedef struct packed {
      spr_data_t pic;
      spr_data_t tt;
      spr_data_t pm;
      spr_data_t dmmu;
      spr_data_t immu;
      spr_data_t mac;
      spr_data_t du;
   } unit_rdata_t;

   typedef struct packed {
      logic pc_we;             // NPC or PPC
      logic epcr_we;
      logic eear_we;
      logic esr_we;
   } sys_we_t;

endpackage

`default_nettype wire

// File: spr_access_ctrl.sv
// SPR access control: CPU vs debug arbitration, address forming and group select decode
`default_nettype none

`include "spr_defines.svh"

module spr_access_ctrl (
   input  wire  spr_pkg::cpu_req_t  cpu_req_i,
   input  wire  spr_pkg::du_req_t   du_req_i,
   input  wire  spr_pkg::spr_data_t rd_data_i,     // From the read mux
   output spr_pkg::spr_addr_t       spr_addr_o,
   output spr_pkg::spr_data_t       spr_dat_o,
   output logic                     spr_we_o,
   output spr_pkg::group_cs_t       spr_cs_o,
   output logic                     read_spr_o,
   output logic                     write_spr_o,
   output spr_pkg::spr_data_t       du_dat_cpu_o
);

   import spr_pkg::*;

   logic      du_access;        // Debug unit owns this cycle
   alu_op_t   sprs_op;          // Effective operation
   spr_addr_t cpu_addr;
   group_cs_t unqualified_cs;   // Raw one-hot decode

   ////////////////////////////////////////////////////////////////////////////
   // Operation select
   ////////////////////////////////////////////////////////////////////////////
   assign du_access = du_req_i.read | du_req_i.write;

   // Debug write first, then debug read, then the pipeline
   assign sprs_op = du_req_i.write ? `SPR_ALUOP_MTSR :
                    du_req_i.read  ? `SPR_ALUOP_MFSR :
                                     cpu_req_i.alu_op;

   assign write_spr_o = (sprs_op == `SPR_ALUOP_MTSR);
   assign read_spr_o  = (sprs_op == `SPR_ALUOP_MFSR);
   assign spr_we_o    = write_spr_o;   // Covers debug writes as well

   ////////////////////////////////////////////////////////////////////////////
   // Address and data
   ////////////////////////////////////////////////////////////////////////////
   // Base ORed with offset, not added
   assign cpu_addr = cpu_req_i.addrbase |
                     {{(`SPR_WIDTH-`SPR_OFS_WIDTH){1'b0}}, cpu_req_i.addrofs};

   assign spr_addr_o = du_access ? du_req_i.addr : cpu_addr;
   assign spr_dat_o  = du_req_i.write ? du_req_i.wdata : cpu_req_i.wdata;

   // Toward the debug unit
   // Its own write data, else the read result, else l.mtspr data
   assign du_dat_cpu_o = du_req_i.write ? du_req_i.wdata :
                         du_req_i.read  ? rd_data_i :
                                          cpu_req_i.wdata;

   ////////////////////////////////////////////////////////////////////////////
   // Group select
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      unqualified_cs = '0;
      unqualified_cs[spr_addr_o[`SPR_GROUP_MSB:`SPR_GROUP_LSB]] = 1'b1;   // One-hot
   end

   // Only live during a real access
   assign spr_cs_o = unqualified_cs & {`SPR_NUM_GROUPS{read_spr_o | write_spr_o}};

endmodule

`default_nettype wire

// File: spr_sys_decode.sv
// System group decode: register selects, write enables and system read data
`default_nettype none

`include "spr_defines.svh"

module spr_sys_decode (
   input  wire  logic                sys_cs_i,      // Group 0, already qualified
   input  wire  spr_pkg::spr_addr_t  spr_addr_i,
   input  wire  logic                read_spr_i,
   input  wire  logic                write_spr_i,
   input  wire  spr_pkg::sr_t        sr_i,
   input  wire  spr_pkg::sys_rdata_t sys_rdata_i,
   output spr_pkg::sys_we_t          sys_we_o,
   output logic                      sr_mtspr_o,    // l.mtspr hits SR
   output spr_pkg::spr_data_t        sys_data_o
);

   import spr_pkg::*;

   logic      cfgr_sel;
   logic      rf_sel;
   logic      npc_sel;
   logic      ppc_sel;
   logic      sr_sel;
   logic      epcr_sel;
   logic      eear_sel;
   logic      esr_sel;
   spr_data_t sr_ext;     // SR zero-extended
   spr_data_t esr_ext;    // ESR zero-extended

   ////////////////////////////////////////////////////////////////////////////
   // Register selects
   ////////////////////////////////////////////////////////////////////////////
   // CFGR and RF cover ranges, the rest are single registers
   assign cfgr_sel = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:4] == `SPR_CFGR);
   assign rf_sel   = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:5] == `SPR_RF);
   assign npc_sel  = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:0] == `SPR_NPC);
   assign sr_sel   = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:0] == `SPR_SR);
   assign ppc_sel  = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:0] == `SPR_PPC);
   assign epcr_sel = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:0] == `SPR_EPCR);
   assign eear_sel = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:0] == `SPR_EEAR);
   assign esr_sel  = sys_cs_i && (spr_addr_i[`SPR_SYS_MSB:0] == `SPR_ESR);

   ////////////////////////////////////////////////////////////////////////////
   // Write enables
   ////////////////////////////////////////////////////////////////////////////
   assign sys_we_o.pc_we   = write_spr_i && (npc_sel | ppc_sel);   // Both write the PC
   assign sys_we_o.epcr_we = write_spr_i && epcr_sel;
   assign sys_we_o.eear_we = write_spr_i && eear_sel;
   assign sys_we_o.esr_we  = write_spr_i && esr_sel;
   assign sr_mtspr_o       = write_spr_i && sr_sel;                 // SR lives next door

   ////////////////////////////////////////////////////////////////////////////
   // Read data
   ////////////////////////////////////////////////////////////////////////////
   assign sr_ext  = {{(`SPR_WIDTH-`SPR_SR_WIDTH){1'b0}}, sr_i};
   assign esr_ext = {{(`SPR_WIDTH-`SPR_SR_WIDTH){1'b0}}, sys_rdata_i.esr};

   // At most one select is set, so an OR of masked words is enough
   assign sys_data_o =
      (sys_rdata_i.cfgr & {`SPR_WIDTH{read_spr_i & cfgr_sel}}) |
      (sys_rdata_i.rf   & {`SPR_WIDTH{read_spr_i & rf_sel}})   |
      (sys_rdata_i.npc  & {`SPR_WIDTH{read_spr_i & npc_sel}})  |
      (sys_rdata_i.ppc  & {`SPR_WIDTH{read_spr_i & ppc_sel}})  |
      (sr_ext           & {`SPR_WIDTH{read_spr_i & sr_sel}})   |
      (sys_rdata_i.epcr & {`SPR_WIDTH{read_spr_i & epcr_sel}}) |
      (sys_rdata_i.eear & {`SPR_WIDTH{read_spr_i & eear_sel}}) |
      (esr_ext          & {`SPR_WIDTH{read_spr_i & esr_sel}});

endmodule

`default_nettype wire

// File: spr_sr_reg.sv
// Supervision register with exception, RFE, ALU and l.mtspr update priority
`default_nettype none

`include "spr_defines.svh"

module spr_sr_reg (
   input  wire  logic                clk,
   input  wire  logic                rst,
   input  wire  spr_pkg::alu_flags_t alu_flags_i,
   input  wire  spr_pkg::branch_op_t branch_op_i,
   input  wire  logic                except_started_i,
   input  wire  logic                sr_mtspr_i,
   input  wire  spr_pkg::spr_data_t  wdata_i,       // l.mtspr data
   input  wire  spr_pkg::sr_t        esr_i,
   output spr_pkg::sr_t              sr_o,
   output logic                      flag_o,
   output logic                      carry_o
);

   import spr_pkg::*;

   sr_t  sr_q;
   sr_t  sr_nxt;    // Value when no exception starts
   logic rfe;

   assign rfe = (branch_op_i == `SPR_BRANCHOP_RFE);

   ////////////////////////////////////////////////////////////////////////////
   // Next value, field by field
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      sr_nxt = sr_q;   // Hold by default
      if (rfe) begin
         sr_nxt = esr_i;   // Whole register back from ESR
      end else begin
         if (sr_mtspr_i) begin
            sr_nxt[`SPR_SR_FO:`SPR_SR_OV] = {1'b1, wdata_i[`SPR_SR_FO-1:`SPR_SR_OV]};
            sr_nxt[`SPR_SR_CY]           = wdata_i[`SPR_SR_CY];
            sr_nxt[`SPR_SR_F]            = wdata_i[`SPR_SR_F];
            sr_nxt[`SPR_SR_CE:`SPR_SR_SM] = wdata_i[`SPR_SR_CE:`SPR_SR_SM];
         end
         // ALU result wins over l.mtspr for F and CY
         if (alu_flags_i.cy_we)
            sr_nxt[`SPR_SR_CY] = alu_flags_i.cyforw;
         if (alu_flags_i.flag_we)
            sr_nxt[`SPR_SR_F] = alu_flags_i.flagforw;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Register
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sr_q <= `SPR_SR_RESET;
      end else if (except_started_i) begin
         sr_q[`SPR_SR_SM]  <= 1'b1;   // Enter supervisor mode
         sr_q[`SPR_SR_TEE] <= 1'b0;   // Tick off
         sr_q[`SPR_SR_IEE] <= 1'b0;   // Interrupts off
         sr_q[`SPR_SR_DME] <= 1'b0;   // MMUs off
         sr_q[`SPR_SR_IME] <= 1'b0;
      end else begin
         sr_q <= sr_nxt;
      end
   end

   assign sr_o    = sr_q;
   assign flag_o  = sr_q[`SPR_SR_F];    // Branch condition
   assign carry_o = sr_q[`SPR_SR_CY];   // For l.addc

endmodule

`default_nettype wire

// File: spr_read_mux.sv
// l.mfspr read data select among the SPR units and the system group
`default_nettype none

`include "spr_defines.svh"

module spr_read_mux (
   input  wire  spr_pkg::group_cs_t   spr_cs_i,
   input  wire  logic                 read_spr_i,
   input  wire  spr_pkg::unit_rdata_t unit_rdata_i,
   input  wire  spr_pkg::spr_data_t   sys_data_i,
   output spr_pkg::spr_data_t         rd_data_o
);

   import spr_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // Select
   ////////////////////////////////////////////////////////////////////////////
   // Selects are one-hot, so masked words can simply be ORed
   always_comb begin
      rd_data_o = '0;   // Idle, writes and unassigned groups
      if (read_spr_i) begin
         rd_data_o =
            (sys_data_i        & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_SYS]}})  |
            (unit_rdata_i.dmmu & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_DMMU]}}) |
            (unit_rdata_i.immu & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_IMMU]}}) |
            (unit_rdata_i.mac  & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_MAC]}})  |
            (unit_rdata_i.du   & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_DU]}})   |
            (unit_rdata_i.pm   & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_PM]}})   |
            (unit_rdata_i.pic  & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_PIC]}})  |
            (unit_rdata_i.tt   & {`SPR_WIDTH{spr_cs_i[`SPR_GROUP_TT]}});
      end
   end

endmodule

`default_nettype wire

// File: spr_unit.sv
// SPR access unit top level, connecting access control, system decode, SR and read mux
`default_nettype none

`include "spr_defines.svh"

module spr_unit (
   input  wire  logic                 clk,
   input  wire  logic                 rst,
   input  wire  spr_pkg::cpu_req_t    cpu_req_i,
   input  wire  spr_pkg::du_req_t     du_req_i,
   input  wire  spr_pkg::alu_flags_t  alu_flags_i,
   input  wire  logic                 except_started_i,
   input  wire  spr_pkg::sys_rdata_t  sys_rdata_i,
   input  wire  spr_pkg::unit_rdata_t unit_rdata_i,
   output spr_pkg::spr_data_t         to_wbmux_o,      // l.mfspr result
   output spr_pkg::spr_addr_t         spr_addr_o,
   output spr_pkg::spr_data_t         spr_dat_o,
   output spr_pkg::group_cs_t         spr_cs_o,
   output logic                       spr_we_o,
   output spr_pkg::spr_data_t         du_dat_cpu_o,
   output spr_pkg::sys_we_t           sys_we_o,
   output spr_pkg::sr_t               sr_o,
   output logic                       flag_o,
   output logic                       carry_o
);

   import spr_pkg::*;

   logic      read_spr;
   logic      write_spr;
   logic      sr_mtspr;
   spr_data_t sys_data;

   ////////////////////////////////////////////////////////////////////////////
   // Instances
   ////////////////////////////////////////////////////////////////////////////
   spr_access_ctrl u_access (
      .cpu_req_i    (cpu_req_i),
      .du_req_i     (du_req_i),
      .rd_data_i    (to_wbmux_o),
      .spr_addr_o   (spr_addr_o),
      .spr_dat_o    (spr_dat_o),
      .spr_we_o     (spr_we_o),
      .spr_cs_o     (spr_cs_o),
      .read_spr_o   (read_spr),
      .write_spr_o  (write_spr),
      .du_dat_cpu_o (du_dat_cpu_o)
   );

   spr_sys_decode u_sys (
      .sys_cs_i    (spr_cs_o[`SPR_GROUP_SYS]),
      .spr_addr_i  (spr_addr_o),
      .read_spr_i  (read_spr),
      .write_spr_i (write_spr),
      .sr_i        (sr_o),
      .sys_rdata_i (sys_rdata_i),
      .sys_we_o    (sys_we_o),
      .sr_mtspr_o  (sr_mtspr),
      .sys_data_o  (sys_data)
   );

   spr_sr_reg u_sr (
      .clk              (clk),
      .rst              (rst),
      .alu_flags_i      (alu_flags_i),
      .branch_op_i      (cpu_req_i.branch_op),
      .except_started_i (except_started_i),
      .sr_mtspr_i       (sr_mtspr),
      .wdata_i          (spr_dat_o),      // Debug or pipeline data
      .esr_i            (sys_rdata_i.esr),
      .sr_o             (sr_o),
      .flag_o           (flag_o),
      .carry_o          (carry_o)
   );

   spr_read_mux u_rmux (
      .spr_cs_i     (spr_cs_o),
      .read_spr_i   (read_spr),
      .unit_rdata_i (unit_rdata_i),
      .sys_data_i   (sys_data),
      .rd_data_o    (to_wbmux_o)
   );

endmodule

`default_nettype wire

// File: tb_spr_unit.sv
// SPR access unit testbench with random decode, read mux, SR update and debug access checks
`default_nettype none

`include "spr_defines.svh"

module tb_spr_unit;

   import spr_pkg::*;

   localparam int CYCLE_LIMIT = 4 * 600;   // Four times the estimated run length

   logic        clk;
   logic        rst;
   cpu_req_t    cpu_req;
   du_req_t     du_req;
   alu_flags_t  alu_flags;
   logic        except_started;
   sys_rdata_t  sys_rdata;
   unit_rdata_t unit_rdata;
   spr_data_t   to_wbmux;
   spr_addr_t   spr_addr;
   spr_data_t   spr_dat;
   group_cs_t   spr_cs;
   logic        spr_we;
   spr_data_t   du_dat_cpu;
   sys_we_t     sys_we;
   sr_t         sr;
   logic        flag;
   logic        carry;
   logic [31:0] lfsr_q;                    // Stimulus generator state
   int          cycles = 0;

   spr_unit dut (
      .clk              (clk),
      .rst              (rst),
      .cpu_req_i        (cpu_req),
      .du_req_i         (du_req),
      .alu_flags_i      (alu_flags),
      .except_started_i (except_started),
      .sys_rdata_i      (sys_rdata),
      .unit_rdata_i     (unit_rdata),
      .to_wbmux_o       (to_wbmux),
      .spr_addr_o       (spr_addr),
      .spr_dat_o        (spr_dat),
      .spr_cs_o         (spr_cs),
      .spr_we_o         (spr_we),
      .du_dat_cpu_o     (du_dat_cpu),
      .sys_we_o         (sys_we),
      .sr_o             (sr),
      .flag_o           (flag),
      .carry_o          (carry)
   );

   always #5 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Checks failed");
         $fatal(1, "Timeout after %0d cycles without reaching the end of the tests", cycles);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   // Galois form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};   // One step per bit
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   function automatic spr_addr_t group_addr(input logic [4:0] g, input logic [10:0] idx);
      group_addr = {16'h0000, g, idx};
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
      assert (act_val === exp_val)
      else begin
         $display("FAILED %s expected %h actual %h", name, exp_val, act_val);
         $display("Checks failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // New cycle on negedge with everything else back to idle
   task automatic drive(input alu_op_t new_op, input spr_addr_t new_base,
                        input spr_ofs_t new_ofs, input spr_data_t new_wdata);
      @(negedge clk);
      cpu_req.alu_op    = new_op;
      cpu_req.branch_op = '0;
      cpu_req.addrbase  = new_base;
      cpu_req.addrofs   = new_ofs;
      cpu_req.wdata     = new_wdata;
      du_req            = '0;
      alu_flags         = '0;
      except_started    = 1'b0;
   endtask

   task automatic settle;
      #4;   // Just before posedge
   endtask

   task automatic past_edge;
      @(posedge clk);
      #1;
   endtask

   task automatic read_check(input spr_addr_t addr, input spr_data_t exp_val, input string name);
      drive(`SPR_ALUOP_MFSR, addr, '0, '0);
      settle();
      check_val(name, exp_val, to_wbmux);
   endtask

   task automatic we_check(input spr_addr_t addr, input logic [3:0] exp_we);
      drive(`SPR_ALUOP_MTSR, addr, '0, '0);
      settle();
      check_val("sys_we_o", 32'(exp_we), 32'(sys_we));
      check_val("spr_we_o", 32'd1, 32'(spr_we));
   endtask

   task automatic sr_check(input sr_t exp_sr);
      check_val("sr_o", 32'(exp_sr), 32'(sr));
      check_val("flag_o", 32'(exp_sr[`SPR_SR_F]), 32'(flag));
      check_val("carry_o", 32'(exp_sr[`SPR_SR_CY]), 32'(carry));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [31:0] w;
      logic [31:0] base;
      logic [31:0] dw;
      logic [31:0] exp_addr;
      spr_ofs_t    ofs;
      alu_op_t     op;
      logic [10:0] idx;
      sr_t         sr_model;   // Expected SR
      int          i;
      clk            = 1'b0;
      rst            = 1'b1;
      lfsr_q         = 32'd90750;
      cpu_req        = '0;
      du_req         = '0;
      alu_flags      = '0;
      except_started = 1'b0;
      sys_rdata      = '0;
      unit_rdata     = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Random read data with ESR in the low 16 bits
      take_bits(16, w);
      sys_rdata.esr = w[15:0];
      for (i = 0; i < 6; i++) begin
         take_bits(32, w);
         sys_rdata[16 + i*32 +: 32] = w;
      end
      for (i = 0; i < 7; i++) begin
         take_bits(32, w);
         unit_rdata[i*32 +: 32] = w;
      end
      sr_model = 16'h8001;
      settle();
      sr_check(sr_model);
      check_val("spr_cs_o", 32'h0, spr_cs);
      check_val("spr_we_o", 32'h0, 32'(spr_we));
      check_val("sys_we_o", 32'h0, 32'(sys_we));

      // Address forming and group decode
      for (i = 0; i < 16; i++) begin
         take_bits(32, base);
         take_bits(16, w);
         ofs = w[15:0];
         exp_addr = base | {16'h0000, ofs};
         drive(`SPR_ALUOP_MFSR, base, ofs, '0);
         settle();
         check_val("spr_addr_o", exp_addr, spr_addr);
         check_val("spr_cs_o", 32'd1 << exp_addr[15:11], spr_cs);
         check_val("spr_we_o", 32'h0, 32'(spr_we));
         ofs[11] = 1'b1;                               // Odd group keeps SR untouched
         exp_addr = base | {16'h0000, ofs};
         drive(`SPR_ALUOP_MTSR, base, ofs, '0);
         settle();
         check_val("spr_cs_o", 32'd1 << exp_addr[15:11], spr_cs);
         check_val("spr_we_o", 32'd1, 32'(spr_we));
         take_bits(4, w);
         op = (w[3:0] >= 4'd14) ? w[3:0] - 4'd2 : w[3:0];   // Neither MTSR nor MFSR
         drive(op, group_addr(5'd0, 11'd64), '0, '0);       // ESR would take a write
         settle();
         check_val("spr_cs_o", 32'h0, spr_cs);
         check_val("spr_we_o", 32'h0, 32'(spr_we));
         check_val("sys_we_o", 32'h0, 32'(sys_we));
      end

      // Read mux over the units and then the system group
      take_bits(11, w);
      idx = w[10:0];
      read_check(group_addr(5'd1, idx), unit_rdata.dmmu, "to_wbmux_o dmmu");
      read_check(group_addr(5'd2, idx), unit_rdata.immu, "to_wbmux_o immu");
      read_check(group_addr(5'd5, idx), unit_rdata.mac, "to_wbmux_o mac");
      read_check(group_addr(5'd6, idx), unit_rdata.du, "to_wbmux_o du");
      read_check(group_addr(5'd8, idx), unit_rdata.pm, "to_wbmux_o pm");
      read_check(group_addr(5'd9, idx), unit_rdata.pic, "to_wbmux_o pic");
      read_check(group_addr(5'd10, idx), unit_rdata.tt, "to_wbmux_o tt");
      read_check(group_addr(5'd3, idx), 32'h0, "to_wbmux_o group 3");
      read_check(group_addr(5'd20, idx), 32'h0, "to_wbmux_o group 20");
      read_check(group_addr(5'd0, 11'h00c), sys_rdata.cfgr, "to_wbmux_o cfgr");
      read_check(group_addr(5'd0, 11'h40b), sys_rdata.rf, "to_wbmux_o rf");
      read_check(group_addr(5'd0, 11'd16), sys_rdata.npc, "to_wbmux_o npc");
      read_check(group_addr(5'd0, 11'd17), {16'h0000, sr_model}, "to_wbmux_o sr");
      read_check(group_addr(5'd0, 11'd18), sys_rdata.ppc, "to_wbmux_o ppc");
      read_check(group_addr(5'd0, 11'd32), sys_rdata.epcr, "to_wbmux_o epcr");
      read_check(group_addr(5'd0, 11'd48), sys_rdata.eear, "to_wbmux_o eear");
      read_check(group_addr(5'd0, 11'd64), {16'h0000, sys_rdata.esr}, "to_wbmux_o esr");
      we_check(group_addr(5'd0, 11'd16), 4'b1000);   // pc_we
      we_check(group_addr(5'd0, 11'd32), 4'b0100);
      we_check(group_addr(5'd0, 11'd48), 4'b0010);
      we_check(group_addr(5'd0, 11'd64), 4'b0001);

      // l.mtspr to SR with a flag write and then a carry write in the last rounds
      for (i = 0; i < 4; i++) begin
         take_bits(32, w);
         w[`SPR_SR_FO] = 1'b0;                         // FO must still come back set
         drive(`SPR_ALUOP_MTSR, group_addr(5'd0, 11'd17), '0, w);
         if (i == 2) begin
            alu_flags.flag_we  = 1'b1;
            alu_flags.flagforw = ~w[`SPR_SR_F];       // Opposite of the l.mtspr bit
         end
         if (i == 3) begin
            alu_flags.cy_we  = 1'b1;
            alu_flags.cyforw = ~w[`SPR_SR_CY];
         end
         sr_model = {1'b1, w[14:0]};                   // FO always set
         if (alu_flags.flag_we)
            sr_model[`SPR_SR_F] = alu_flags.flagforw;
         if (alu_flags.cy_we)
            sr_model[`SPR_SR_CY] = alu_flags.cyforw;
         past_edge();
         sr_check(sr_model);
         read_check(group_addr(5'd0, 11'd17), {16'h0000, sr_model}, "to_wbmux_o sr");
      end

      // Known SR with SM clear and every enable set
      sr_model = (sr_model & ~16'h0001) | 16'h0066;
      drive(`SPR_ALUOP_MTSR, group_addr(5'd0, 11'd17), '0, {16'h0000, sr_model});
      past_edge();
      sr_check(sr_model);

      ////////////////////////////////////////////////////////////////////////////
      // Exceptions and RFE
      ////////////////////////////////////////////////////////////////////////////
      drive('0, '0, '0, '0);
      except_started = 1'b1;
      sr_model = (sr_model | 16'h0001) & ~16'h0066;   // SM on, TEE IEE DME IME off
      past_edge();
      sr_check(sr_model);
      drive('0, '0, '0, '0);
      except_started    = 1'b1;
      cpu_req.branch_op = `SPR_BRANCHOP_RFE;           // Loses to the exception
      past_edge();
      sr_check(sr_model);
      drive('0, '0, '0, '0);
      cpu_req.branch_op = `SPR_BRANCHOP_RFE;
      sr_model = sys_rdata.esr;
      past_edge();
      sr_check(sr_model);

      // Debug write over a CPU read
      take_bits(32, base);
      take_bits(32, w);
      take_bits(32, dw);
      take_bits(32, exp_addr);
      exp_addr[11] = 1'b1;                             // Keep clear of SR
      drive(`SPR_ALUOP_MFSR, base, '0, w);
      du_req.addr  = exp_addr;
      du_req.wdata = dw;
      du_req.write = 1'b1;
      settle();
      check_val("spr_addr_o", exp_addr, spr_addr);
      check_val("spr_dat_o", dw, spr_dat);
      check_val("du_dat_cpu_o", dw, du_dat_cpu);
      check_val("spr_we_o", 32'd1, 32'(spr_we));
      check_val("spr_cs_o", 32'd1 << exp_addr[15:11], spr_cs);
      // Debug read of the PIC
      drive('0, base, '0, w);
      du_req.addr = group_addr(5'd9, idx);
      du_req.read = 1'b1;
      settle();
      check_val("to_wbmux_o", unit_rdata.pic, to_wbmux);
      check_val("du_dat_cpu_o", unit_rdata.pic, du_dat_cpu);
      check_val("spr_we_o", 32'h0, 32'(spr_we));
      // No debug access
      drive('0, base, '0, w);
      settle();
      check_val("du_dat_cpu_o", w, du_dat_cpu);
      check_val("spr_dat_o", w, spr_dat);

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
spr_pkg.sv
spr_access_ctrl.sv
spr_sys_decode.sv
spr_sr_reg.sv
spr_read_mux.sv
spr_unit.sv
tb_spr_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the SPR unit testbench with Verilator, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_spr_unit -o tb_spr_unit &&
./obj_dir/tb_spr_unit ||
{ echo "Simulation failed"; exit 1; }
